// File: src/eboxPkg.sv
package eboxPkg;

  // one PDP-10 word.
  localparam int ebusBits = 36;

  typedef logic [ebusBits-1:0] ebusWord;

  // edp operations; all take one AC and an immediate operand.
  typedef enum logic [2:0] {
    opMove = 3'd0,
    opAdd  = 3'd1,
    opSub  = 3'd2,
    opAnd  = 3'd3,
    opIor  = 3'd4,
    opXor  = 3'd5
  } opCode;

endpackage

// File: src/fastMem.sv
`timescale 1ns/1ps

module fastMem import eboxPkg::*; #(
  parameter int acBits = 4
) (
  input  logic              eboxClk,
  input  logic [acBits-1:0] fmAdr,
  input  logic              fmWrite,
  input  ebusWord           fmWrData,
  output ebusWord           fmRdData
);

  localparam int acCount = 2 ** acBits;

  ebusWord acRam [acCount];

  // read returns the old word when the same address is written.
  always_ff @(posedge eboxClk) begin
    if (fmWrite) begin
      acRam[fmAdr] <= fmWrData;
    end
    fmRdData <= acRam[fmAdr];
  end

endmodule

// File: src/fmArbiter.sv
`timescale 1ns/1ps

module fmArbiter import eboxPkg::*; #(
  parameter int acBits = 4
) (
  input  logic              eboxClk,
  input  logic              reset,

  input  logic              edpMemReq,
  input  logic              edpMemWrite,
  input  logic [acBits-1:0] edpMemAdr,
  input  ebusWord           edpMemWrData,
  output logic              edpMemAck,
  output ebusWord           edpMemRdData,

  input  logic              diagMemReq,
  input  logic              diagMemWrite,
  input  logic [acBits-1:0] diagMemAdr,
  input  ebusWord           diagMemWrData,
  output logic              diagMemAck,
  output ebusWord           diagMemRdData,

  output logic [acBits-1:0] fmAdr,
  output logic              fmWrite,
  output ebusWord           fmWrData,
  input  ebusWord           fmRdData
);

  typedef enum logic [1:0] {
    arbIdle,
    arbAccess,
    arbCapture,
    arbAck
  } arbState;

  arbState state;
  logic    winnerDiag;    // last winner; selects the client while a grant is held.
  logic    pickDiag;
  logic    winnerReq;
  logic    ackOn;
  ebusWord rdHold;
  ebusWord rdData;

  // diag wins alone, or on a tie when edp had the last turn.
  assign pickDiag  = diagMemReq && (!edpMemReq || !winnerDiag);
  assign winnerReq = winnerDiag ? diagMemReq : edpMemReq;

  always_ff @(posedge eboxClk) begin
    if (reset) begin
      state      <= arbIdle;
      winnerDiag <= 1'b1; // so edp has the first turn.
    end else begin
      unique case (state)
        arbIdle: begin
          if (edpMemReq || diagMemReq) begin
            winnerDiag <= pickDiag;
            state      <= arbAccess;
          end
        end
        arbAccess:  state <= arbCapture;
        arbCapture: state <= arbAck;
        arbAck: begin
          if (!winnerReq) begin
            state <= arbIdle; // client released.
          end
        end
        default: state <= arbIdle;
      endcase
    end
  end

  always_ff @(posedge eboxClk) begin
    if (state == arbCapture) begin
      rdHold <= fmRdData;
    end
  end

  // memory word is fresh in capture, held after that.
  assign rdData = (state == arbCapture) ? fmRdData : rdHold;
  assign ackOn  = (state == arbCapture) || (state == arbAck);

  assign fmAdr    = winnerDiag ? diagMemAdr : edpMemAdr;
  assign fmWrData = winnerDiag ? diagMemWrData : edpMemWrData;
  assign fmWrite  = (state == arbAccess) && (winnerDiag ? diagMemWrite : edpMemWrite);

  assign edpMemAck     = ackOn && !winnerDiag;
  assign diagMemAck    = ackOn && winnerDiag;
  assign edpMemRdData  = edpMemAck ? rdData : '0;
  assign diagMemRdData = diagMemAck ? rdData : '0;

endmodule

// File: src/edp.sv
`timescale 1ns/1ps

module edp import eboxPkg::*; #(
  parameter int acBits = 4
) (
  input  logic              eboxClk,
  input  logic              reset,

  input  logic              instReq,
  input  opCode             instOp,
  input  logic [acBits-1:0] instAc,
  input  ebusWord           instOperand,
  output logic              instAck,
  output ebusWord           instResult,

  output logic              edpMemReq,
  output logic              edpMemWrite,
  output logic [acBits-1:0] edpMemAdr,
  output ebusWord           edpMemWrData,
  input  logic              edpMemAck,
  input  ebusWord           edpMemRdData
);

  typedef enum logic [2:0] {
    edpIdle,
    edpRead,
    edpRelease,
    edpCompute,
    edpWrite,
    edpFinish,
    edpDone
  } edpState;

  edpState           state;
  opCode             opReg;
  logic [acBits-1:0] acReg;
  ebusWord           operandReg;
  ebusWord           acValue;
  ebusWord           resultReg;
  ebusWord           aluOut;

  always_ff @(posedge eboxClk) begin
    if (reset) begin
      state <= edpIdle;
    end else begin
      unique case (state)
        edpIdle: begin
          if (instReq) begin
            state <= (instOp == opMove) ? edpCompute : edpRead; // move skips the fetch.
          end
        end
        edpRead: begin
          if (edpMemAck) begin
            state <= edpRelease;
          end
        end
        edpRelease: begin
          if (!edpMemAck) begin
            state <= edpCompute;
          end
        end
        edpCompute: state <= edpWrite;
        edpWrite: begin
          if (edpMemAck) begin
            state <= edpFinish;
          end
        end
        edpFinish: begin
          if (!edpMemAck) begin
            state <= edpDone;
          end
        end
        edpDone: begin
          if (!instReq) begin
            state <= edpIdle;
          end
        end
        default: state <= edpIdle;
      endcase
    end
  end

  always_ff @(posedge eboxClk) begin
    if (state == edpIdle && instReq) begin
      opReg      <= instOp;
      acReg      <= instAc;
      operandReg <= instOperand;
    end
    if (state == edpRead && edpMemAck) begin
      acValue <= edpMemRdData;
    end
    if (state == edpCompute) begin
      resultReg <= aluOut;
    end
  end

  // 36-bit alu, wraps without flags.
  always_comb begin
    unique case (opReg)
      opMove:  aluOut = operandReg;
      opAdd:   aluOut = acValue + operandReg;
      opSub:   aluOut = acValue - operandReg;
      opAnd:   aluOut = acValue & operandReg;
      opIor:   aluOut = acValue | operandReg;
      opXor:   aluOut = acValue ^ operandReg;
      default: aluOut = operandReg;
    endcase
  end

  assign edpMemReq    = (state == edpRead) || (state == edpWrite);
  assign edpMemWrite  = (state == edpWrite);
  assign edpMemAdr    = acReg;
  assign edpMemWrData = resultReg;

  assign instAck    = (state == edpDone);
  assign instResult = resultReg;

endmodule

// File: src/diagPort.sv
`timescale 1ns/1ps

module diagPort import eboxPkg::*; #(
  parameter int acBits = 4
) (
  input  logic              eboxClk,
  input  logic              reset,

  input  logic              diagReq,
  input  logic              diagWrite,
  input  logic [acBits-1:0] diagAc,
  input  ebusWord           diagWrData,
  output logic              diagAck,
  output ebusWord           diagRdData,

  output logic              diagMemReq,
  output logic              diagMemWrite,
  output logic [acBits-1:0] diagMemAdr,
  output ebusWord           diagMemWrData,
  input  logic              diagMemAck,
  input  ebusWord           diagMemRdData
);

  typedef enum logic [1:0] {
    diagIdle,
    diagAccess,
    diagRelease,
    diagDone
  } diagState;

  diagState          state;
  logic              writeReg;
  logic [acBits-1:0] acReg;
  ebusWord           wrDataReg;
  ebusWord           rdDataReg;

  always_ff @(posedge eboxClk) begin
    if (reset) begin
      state <= diagIdle;
    end else begin
      unique case (state)
        diagIdle:    if (diagReq) state <= diagAccess;
        diagAccess:  if (diagMemAck) state <= diagRelease;
        diagRelease: if (!diagMemAck) state <= diagDone; // memory cycle closed.
        diagDone:    if (!diagReq) state <= diagIdle;
        default:     state <= diagIdle;
      endcase
    end
  end

  always_ff @(posedge eboxClk) begin
    if (state == diagIdle && diagReq) begin
      writeReg  <= diagWrite;
      acReg     <= diagAc;
      wrDataReg <= diagWrData;
    end
    if (state == diagAccess && diagMemAck) begin
      rdDataReg <= diagMemRdData;
    end
  end

  assign diagMemReq    = (state == diagAccess);
  assign diagMemWrite  = writeReg;
  assign diagMemAdr    = acReg;
  assign diagMemWrData = wrDataReg;

  assign diagAck    = (state == diagDone);
  assign diagRdData = rdDataReg; // only meaningful on a read.

endmodule

// File: src/ebox.sv
`timescale 1ns/1ps

module ebox import eboxPkg::*; #(
  parameter int acBits = 4
) (
  input  logic              eboxClk,
  input  logic              reset,

  input  logic              instReq,
  input  opCode             instOp,
  input  logic [acBits-1:0] instAc,
  input  ebusWord           instOperand,
  output logic              instAck,
  output ebusWord           instResult,

  input  logic              diagReq,
  input  logic              diagWrite,
  input  logic [acBits-1:0] diagAc,
  input  ebusWord           diagWrData,
  output logic              diagAck,
  output ebusWord           diagRdData
);

  // edp client of the arbiter.
  logic              edpMemReq;
  logic              edpMemWrite;
  logic [acBits-1:0] edpMemAdr;
  ebusWord           edpMemWrData;
  logic              edpMemAck;
  ebusWord           edpMemRdData;

  // diagnostic client.
  logic              diagMemReq;
  logic              diagMemWrite;
  logic [acBits-1:0] diagMemAdr;
  ebusWord           diagMemWrData;
  logic              diagMemAck;
  ebusWord           diagMemRdData;

  // fast memory side, owned by the arbiter.
  logic [acBits-1:0] fmAdr;
  logic              fmWrite;
  ebusWord           fmWrData;
  ebusWord           fmRdData;

  fastMem #(
    .acBits(acBits)
  ) fastMem0 (.*);

  fmArbiter #(
    .acBits(acBits)
  ) fmArbiter0 (.*);

  edp #(
    .acBits(acBits)
  ) edp0 (.*);

  diagPort #(
    .acBits(acBits)
  ) diagPort0 (.*);

endmodule // ebox

// File: bench/fmArbiter_chk.sv
`timescale 1ns/1ps

module fmArbiterChk (
  input logic eboxClk,
  input logic reset,
  input logic edpMemReq,
  input logic edpMemAck,
  input logic diagMemReq,
  input logic diagMemAck,
  input logic fmWrite,
  input logic winnerReq
);

  int assertFails = 0; // failed assertions so far.

  function automatic void noteFail(input string msg);
    assertFails++;
    $error("%s", msg);
  endfunction

  // a grant reaches the other client only through idle.
  edpAckExclusive: assert property (@(posedge eboxClk) disable iff (reset)
      edpMemAck |=> !diagMemAck)
    else noteFail("diag ack followed an edp ack directly");

  diagAckExclusive: assert property (@(posedge eboxClk) disable iff (reset)
      diagMemAck |=> !edpMemAck)
    else noteFail("edp ack followed a diag ack directly");

  edpAckRise: assert property (@(posedge eboxClk) disable iff (reset)
      $rose(edpMemAck) |-> edpMemReq)
    else noteFail("edp ack rose without a request");

  diagAckRise: assert property (@(posedge eboxClk) disable iff (reset)
      $rose(diagMemAck) |-> diagMemReq)
    else noteFail("diag ack rose without a request");

  // once granted, the ack lasts as long as the client holds on.
  edpAckHold: assert property (@(posedge eboxClk) disable iff (reset)
      edpMemAck && edpMemReq |=> edpMemAck)
    else noteFail("edp ack dropped while its request was held");

  diagAckHold: assert property (@(posedge eboxClk) disable iff (reset)
      diagMemAck && diagMemReq |=> diagMemAck)
    else noteFail("diag ack dropped while its request was held");

  writeInGrant: assert property (@(posedge eboxClk) disable iff (reset)
      fmWrite |-> winnerReq)
    else noteFail("memory write without a held grant");

endmodule

bind fmArbiter fmArbiterChk arbChk (
  .eboxClk    (eboxClk),
  .reset      (reset),
  .edpMemReq  (edpMemReq),
  .edpMemAck  (edpMemAck),
  .diagMemReq (diagMemReq),
  .diagMemAck (diagMemAck),
  .fmWrite    (fmWrite),
  .winnerReq  (winnerReq)
);

// File: bench/eboxTb.sv
`timescale 1ns/1ps

module eboxTb import eboxPkg::*; ();

  localparam int acBits = 4; // the ebox default.
  localparam int acCount = 2 ** acBits;
  localparam int halfCount = acCount / 2;
  localparam int cycleLimit = 6000; // about 300 transactions of up to 20 cycles.
  localparam longint unsigned wordSpan = 64'd1 << 36;

  logic              eboxClk = 1'b0;
  logic              reset;
  logic              instReq;
  opCode             instOp;
  logic [acBits-1:0] instAc;
  ebusWord           instOperand;
  logic              instAck;
  ebusWord           instResult;
  logic              diagReq;
  logic              diagWrite;
  logic [acBits-1:0] diagAc;
  ebusWord           diagWrData;
  logic              diagAck;
  ebusWord           diagRdData;

  ebusWord acModel [acCount]; // reference copy of the ACs.
  int      passCount = 0;
  int      failCount = 0;
  int      cycleCount = 0;

  ebox i_ebox (.*);

  always #5 eboxClk = ~eboxClk;

  always @(posedge eboxClk) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= cycleLimit) begin
      $display("Timeout: a port stopped answering, run not done after %0d cycles.", cycleLimit);
      $display("CHECKS FAILED");
      $finish;
    end
  end

  function automatic ebusWord randomWord();
    return ebusWord'({$urandom(), $urandom()});
  endfunction

  // new AC value by the instruction rules, arithmetic modulo 2**36.
  function automatic ebusWord expectedResult(opCode op, ebusWord ac, ebusWord operand);
    case (op)
      opAdd:   return ebusWord'((64'(ac) + 64'(operand)) % wordSpan);
      opSub:   return ebusWord'((wordSpan + 64'(ac) - 64'(operand)) % wordSpan);
      opAnd:   return ac & operand;
      opIor:   return ac | operand;
      opXor:   return ac ^ operand;
      default: return operand; // move.
    endcase
  endfunction

  task automatic checkWord(input string what, input ebusWord got, input ebusWord expected);
    assert (got === expected) begin
      passCount++;
    end else begin
      failCount++;
      $display("Error at %0t: %s is %h, expected %h", $time, what, got, expected);
    end
  endtask

  task automatic reportTest(input string name, input int failsBefore);
    $display("test %s finished with %0d errors", name, failCount - failsBefore);
  endtask

  // four-phase cycles; each starts and ends just after a rising edge.
  task automatic runInst(input opCode op, input logic [acBits-1:0] ac, input ebusWord operand,
                         output ebusWord result);
    instReq     <= 1'b1;
    instOp      <= op;
    instAc      <= ac;
    instOperand <= operand;
    do @(posedge eboxClk); while (!instAck);
    result = instResult;
    instReq <= 1'b0;
    do @(posedge eboxClk); while (instAck);
  endtask

  task automatic runDiag(input logic write, input logic [acBits-1:0] ac, input ebusWord wrData,
                         output ebusWord rdData);
    diagReq    <= 1'b1;
    diagWrite  <= write;
    diagAc     <= ac;
    diagWrData <= wrData;
    do @(posedge eboxClk); while (!diagAck);
    rdData = diagRdData;
    diagReq <= 1'b0;
    do @(posedge eboxClk); while (diagAck);
  endtask

  task automatic resetTest();
    int fails;
    int i;
    fails = failCount;
    for (i = 0; i < 8; i++) begin
      @(posedge eboxClk);
      if (i > 0) begin // outputs are unknown before the first edge.
        checkWord("instAck in reset", ebusWord'(instAck), '0);
        checkWord("diagAck in reset", ebusWord'(diagAck), '0);
      end
    end
    reset <= 1'b0;
    @(posedge eboxClk);
    checkWord("instAck after reset", ebusWord'(instAck), '0);
    checkWord("diagAck after reset", ebusWord'(diagAck), '0);
    reportTest("reset", fails);
  endtask

  task automatic diagRoundTrip();
    int fails;
    int i;
    ebusWord word;
    fails = failCount;
    for (i = 0; i < acCount; i++) begin
      acModel[i] = randomWord();
      runDiag(1'b1, acBits'(i), acModel[i], word);
    end
    for (i = 0; i < acCount; i++) begin
      runDiag(1'b0, acBits'(i), '0, word);
      checkWord($sformatf("diag read of AC%0d", i), word, acModel[i]);
    end
    reportTest("diag round trip", fails);
  endtask

  task automatic instResults();
    int fails;
    int o;
    opCode op;
    logic [acBits-1:0] ac;
    ebusWord operand;
    ebusWord expected;
    ebusWord word;
    fails = failCount;
    for (o = 0; o < 6; o++) begin
      op = opCode'(o);
      repeat (4) begin
        ac = acBits'($urandom_range(acCount - 1, 0));
        operand = randomWord();
        expected = expectedResult(op, acModel[ac], operand);
        runInst(op, ac, operand, word);
        checkWord($sformatf("%s result", op.name()), word, expected);
        acModel[ac] = expected;
        runDiag(1'b0, ac, '0, word);
        checkWord($sformatf("AC%0d after %s", ac, op.name()), word, expected);
      end
    end
    reportTest("instruction results", fails);
  endtask

  // instructions work on the low half of the ACs, diag traffic on the high half.
  task automatic concurrentTest();
    int fails;
    fails = failCount;
    fork
      begin
        opCode op;
        logic [acBits-1:0] ac;
        ebusWord operand;
        ebusWord expected;
        ebusWord word;
        repeat (100) begin
          ac = acBits'($urandom_range(halfCount - 1, 0));
          op = opCode'($urandom_range(5, 0));
          operand = randomWord();
          expected = expectedResult(op, acModel[ac], operand);
          runInst(op, ac, operand, word);
          checkWord("instruction under load", word, expected);
          acModel[ac] = expected;
        end
      end
      begin
        logic [acBits-1:0] ac;
        ebusWord word;
        repeat (100) begin
          ac = acBits'(halfCount + $urandom_range(halfCount - 1, 0));
          if ($urandom_range(1, 0) == 1) begin
            acModel[ac] = randomWord();
            runDiag(1'b1, ac, acModel[ac], word);
          end else begin
            runDiag(1'b0, ac, '0, word);
            checkWord("diag read under load", word, acModel[ac]);
          end
        end
      end
    join
    reportTest("concurrent traffic", fails);
  endtask

  task automatic backPressureTest();
    int fails;
    logic [acBits-1:0] ac;
    ebusWord operand;
    ebusWord expected;
    fails = failCount;
    ac = acBits'(3);
    operand = randomWord();
    expected = expectedResult(opAdd, acModel[ac], operand);
    fork
      begin
        instReq     <= 1'b1;
        instOp      <= opAdd;
        instAc      <= ac;
        instOperand <= operand;
        do @(posedge eboxClk); while (!instAck);
        checkWord("held ADD result", instResult, expected);
        repeat (20) begin
          @(posedge eboxClk);
          checkWord("instAck while held", ebusWord'(instAck), ebusWord'(1));
        end
        instReq <= 1'b0;
        do @(posedge eboxClk); while (instAck);
      end
      begin
        ebusWord word;
        do @(posedge eboxClk); while (!instAck);
        runDiag(1'b0, ac, '0, word);
        checkWord("diag read during hold", word, expected);
      end
    join
    acModel[ac] = expected;
    reportTest("back-pressure", fails);
  endtask

  initial begin
    void'($urandom(9));
    reset       = 1'b1;
    instReq     = 1'b0;
    instOp      = opMove;
    instAc      = '0;
    instOperand = '0;
    diagReq     = 1'b0;
    diagWrite   = 1'b0;
    diagAc      = '0;
    diagWrData  = '0;
    resetTest();
    diagRoundTrip();
    instResults();
    concurrentTest();
    backPressureTest();
    failCount += i_ebox.fmArbiter0.arbChk.assertFails; // bound arbiter assertions.
    $display("summary: %0d checks passed, %0d failed", passCount, failCount);
    if (failCount == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

// File: files.f
src/eboxPkg.sv
src/fastMem.sv
src/fmArbiter.sv
src/edp.sv
src/diagPort.sv
src/ebox.sv
bench/fmArbiter_chk.sv
bench/eboxTb.sv

// File: Bender.yml
package:
  name: ebox

sources:
  - src/eboxPkg.sv
  - src/fastMem.sv
  - src/fmArbiter.sv
  - src/edp.sv
  - src/diagPort.sv
  - src/ebox.sv
  - target: test
    files:
      - bench/fmArbiter_chk.sv
      - bench/eboxTb.sv
